// File: design/mips_alu.sv
`timescale 1ns/1ps

module mips_alu import mips_pkg::*; (
    input  logic [31:0] instr,
    input  ctrl_t       ctrl,
    input  logic [31:0] op_a,
    input  logic [31:0] op_b,
    output logic [31:0] result,
    output logic [31:0] hi_result,
    output logic [31:0] lo_result,
    output logic [31:0] eff_addr,
    output logic        take_branch
);

    opcode_e     op;
    logic [31:0] imm_ext;
    logic [31:0] operand_b;
    logic [4:0]  shamt;
    logic [63:0] product_s;
    logic [63:0] product_u;
    logic        branch_cond;

    assign op = opcode_e'(instr[31:26]);
    assign imm_ext = ctrl.imm_zero_ext ? {16'd0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign operand_b = ctrl.use_imm ? imm_ext : op_b;
    // shifts act on rt, by shamt or by rs
    assign shamt = ctrl.shift_by_reg ? op_a[4:0] : instr[10:6];
    assign eff_addr = op_a + {{16{instr[15]}}, instr[15:0]};

    // low 64 bits of sign-extended product equal the signed product
    assign product_s = {{32{op_a[31]}}, op_a} * {{32{op_b[31]}}, op_b};
    assign product_u = {32'd0, op_a} * {32'd0, op_b};

    always_comb begin
        case (ctrl.alu_op)
            alu_add:  result = op_a + operand_b;
            alu_sub:  result = op_a - operand_b;
            alu_and:  result = op_a & operand_b;
            alu_or:   result = op_a | operand_b;
            alu_xor:  result = op_a ^ operand_b;
            alu_nor:  result = ~(op_a | operand_b);
            alu_slt:  result = {31'd0, $signed(op_a) < $signed(operand_b)};
            alu_sltu: result = {31'd0, op_a < operand_b};
            alu_sll:  result = op_b << shamt;
            alu_srl:  result = op_b >> shamt;
            alu_sra:  result = $signed(op_b) >>> shamt;
            alu_lui:  result = {instr[15:0], 16'd0};
            alu_pass: result = op_a;
            default:  result = '0;
        endcase
    end

    always_comb begin
        hi_result = '0;
        lo_result = '0;
        case (ctrl.alu_op)
            alu_mult:  {hi_result, lo_result} = product_s;
            alu_multu: {hi_result, lo_result} = product_u;
            alu_div: begin
                // divide by zero leaves both halves zero
                if (op_b != 32'd0) begin
                    lo_result = $signed(op_a) / $signed(op_b);
                    hi_result = $signed(op_a) % $signed(op_b);
                end
            end
            alu_divu: begin
                if (op_b != 32'd0) begin
                    lo_result = op_a / op_b;
                    hi_result = op_a % op_b;
                end
            end
            default: begin
                hi_result = '0;
                lo_result = '0;
            end
        endcase
    end

    always_comb begin
        case (op)
            op_beq:    branch_cond = (op_a == op_b);
            op_bne:    branch_cond = (op_a != op_b);
            op_blez:   branch_cond = op_a[31] || (op_a == 32'd0);
            op_bgtz:   branch_cond = !op_a[31] && (op_a != 32'd0);
            // rt bit 0 picks bgez over bltz
            op_regimm: branch_cond = instr[16] ? !op_a[31] : op_a[31];
            default:   branch_cond = 1'b0;
        endcase
    end

    assign take_branch = ctrl.branch && branch_cond;

endmodule

// File: design/mips_control.sv
`timescale 1ns/1ps

module mips_control import mips_pkg::*; (
    input  logic [31:0] instr,
    output ctrl_t       ctrl
);

    opcode_e op;
    funct_e  fn;

    assign op = opcode_e'(instr[31:26]);
    assign fn = funct_e'(instr[5:0]);

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = alu_pass;
        ctrl.mem_size = size_word;
        case (op)
            op_special: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst_rd = 1'b1;
                case (fn)
                    fn_sll:  ctrl.alu_op = alu_sll;
                    fn_srl:  ctrl.alu_op = alu_srl;
                    fn_sra:  ctrl.alu_op = alu_sra;
                    fn_sllv: begin
                        ctrl.alu_op = alu_sll;
                        ctrl.shift_by_reg = 1'b1;
                    end
                    fn_srlv: begin
                        ctrl.alu_op = alu_srl;
                        ctrl.shift_by_reg = 1'b1;
                    end
                    fn_srav: begin
                        ctrl.alu_op = alu_sra;
                        ctrl.shift_by_reg = 1'b1;
                    end
                    fn_jr: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.jump_reg = 1'b1;
                    end
                    fn_jalr: begin
                        ctrl.jump_reg = 1'b1;
                        ctrl.link = 1'b1;
                    end
                    fn_mfhi: ctrl.from_hi = 1'b1;
                    fn_mflo: ctrl.from_lo = 1'b1;
                    fn_mult, fn_multu, fn_div, fn_divu: begin
                        // result goes to hi/lo only
                        ctrl.reg_write = 1'b0;
                        ctrl.muldiv = 1'b1;
                        case (fn)
                            fn_mult:  ctrl.alu_op = alu_mult;
                            fn_multu: ctrl.alu_op = alu_multu;
                            fn_div:   ctrl.alu_op = alu_div;
                            default:  ctrl.alu_op = alu_divu;
                        endcase
                    end
                    fn_add, fn_addu: ctrl.alu_op = alu_add;
                    fn_sub, fn_subu: ctrl.alu_op = alu_sub;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_xor:  ctrl.alu_op = alu_xor;
                    fn_nor:  ctrl.alu_op = alu_nor;
                    fn_slt:  ctrl.alu_op = alu_slt;
                    fn_sltu: ctrl.alu_op = alu_sltu;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            op_regimm: begin
                ctrl.branch = 1'b1;
                // bltzal and bgezal link even when not taken
                ctrl.link = instr[20];
                ctrl.link_ra = instr[20];
                ctrl.reg_write = instr[20];
            end
            op_j: ctrl.jump_imm = 1'b1;
            op_jal: begin
                ctrl.jump_imm = 1'b1;
                ctrl.link = 1'b1;
                ctrl.link_ra = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_beq, op_bne, op_blez, op_bgtz: ctrl.branch = 1'b1;
            op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.imm_zero_ext = (op == op_andi) || (op == op_ori) || (op == op_xori);
                case (op)
                    op_slti:  ctrl.alu_op = alu_slt;
                    op_sltiu: ctrl.alu_op = alu_sltu;
                    op_andi:  ctrl.alu_op = alu_and;
                    op_ori:   ctrl.alu_op = alu_or;
                    op_xori:  ctrl.alu_op = alu_xor;
                    op_lui:   ctrl.alu_op = alu_lui;
                    default:  ctrl.alu_op = alu_add;
                endcase
            end
            op_lb, op_lbu, op_lh, op_lhu, op_lw: begin
                ctrl.mem_read = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.load_unsigned = (op == op_lbu) || (op == op_lhu);
                if (op == op_lb || op == op_lbu) begin
                    ctrl.mem_size = size_byte;
                end else if (op == op_lh || op == op_lhu) begin
                    ctrl.mem_size = size_half;
                end
            end
            op_sb: begin
                ctrl.mem_write = 1'b1;
                ctrl.mem_size = size_byte;
            end
            op_sh: begin
                ctrl.mem_write = 1'b1;
                ctrl.mem_size = size_half;
            end
            op_sw: ctrl.mem_write = 1'b1;
            // unknown opcodes decode as a nop
            default: ;
        endcase
    end

endmodule

// File: design/mips_cpu_harvard.sv
`timescale 1ns/1ps

module mips_cpu_harvard import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    output logic        active,
    output logic [31:0] register_v0,
    input  logic        clk_enable,
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);

    ctrl_t       ctrl;
    cpu_state_e  state;
    logic [31:0] pc;
    logic [31:0] delay_slot;
    logic [31:0] next_delay_slot;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] old_word;
    logic [31:0] reg_a;
    logic [31:0] reg_b;
    logic [31:0] result;
    logic [31:0] hi_result;
    logic [31:0] lo_result;
    logic [31:0] eff_addr;
    logic [31:0] load_value;
    logic        take_branch;
    logic        commit;
    logic        partial_store;
    logic [4:0]  write_index;
    logic [31:0] write_data;

    mips_control u_control (.instr(instr_readdata), .ctrl(ctrl));

    assign commit = active && (state == st_execute);
    assign partial_store = ctrl.mem_write && (ctrl.mem_size != size_word);

    assign write_index = ctrl.link_ra ? link_reg_index
                       : (ctrl.reg_dst_rd ? instr_readdata[15:11] : instr_readdata[20:16]);

    always_comb begin
        if (ctrl.link) begin
            write_data = delay_slot + 32'd4;
        end else if (ctrl.from_hi) begin
            write_data = hi;
        end else if (ctrl.from_lo) begin
            write_data = lo;
        end else if (ctrl.mem_read) begin
            write_data = load_value;
        end else begin
            write_data = result;
        end
    end

    mips_regfile u_regfile (
        .clk(clk),
        .reset(reset),
        .clk_enable(clk_enable),
        .read_index_a(instr_readdata[25:21]),
        .read_index_b(instr_readdata[20:16]),
        .write_enable(commit && ctrl.reg_write),
        .write_index(write_index),
        .write_data(write_data),
        .read_data_a(reg_a),
        .read_data_b(reg_b),
        .register_v0(register_v0)
    );

    mips_alu u_alu (
        .instr(instr_readdata),
        .ctrl(ctrl),
        .op_a(reg_a),
        .op_b(reg_b),
        .result(result),
        .hi_result(hi_result),
        .lo_result(lo_result),
        .eff_addr(eff_addr),
        .take_branch(take_branch)
    );

    mips_load_align u_load_align (
        .byte_offset(eff_addr[1:0]),
        .size(ctrl.mem_size),
        .load_unsigned(ctrl.load_unsigned),
        .mem_word(data_readdata),
        .load_value(load_value)
    );

    mips_store_merge u_store_merge (
        .byte_offset(eff_addr[1:0]),
        .size(ctrl.mem_size),
        .reg_value(reg_b),
        .old_word(old_word),
        .store_word(data_writedata)
    );

    assign instr_address = pc;
    assign data_address = {eff_addr[31:2], 2'b00};
    assign data_write = commit && ctrl.mem_write;
    // partial stores read the old word while fetching
    assign data_read = active && ((state == st_execute && ctrl.mem_read)
                                  || (state == st_fetch && partial_store));

    always_comb begin
        if (take_branch) begin
            next_delay_slot = delay_slot + {{14{instr_readdata[15]}}, instr_readdata[15:0], 2'b00};
        end else if (ctrl.jump_imm) begin
            next_delay_slot = {delay_slot[31:28], instr_readdata[25:0], 2'b00};
        end else if (ctrl.jump_reg) begin
            next_delay_slot = reg_a;
        end else begin
            next_delay_slot = delay_slot + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            if (reset) begin
                pc <= reset_pc;
                delay_slot <= reset_pc + 32'd4;
                state <= st_fetch;
                active <= 1'b1;
            end else if (active) begin
                if (state == st_fetch) begin
                    state <= st_execute;
                end else begin
                    state <= st_fetch;
                    pc <= delay_slot;
                    delay_slot <= next_delay_slot;
                end
                // control has reached address 0
                if (delay_slot == 32'd0) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            if (reset) begin
                hi <= '0;
                lo <= '0;
            end else if (commit && ctrl.muldiv) begin
                hi <= hi_result;
                lo <= lo_result;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable && state == st_fetch && partial_store) begin
            old_word <= data_readdata;
        end
    end

endmodule

// File: design/mips_load_align.sv
`timescale 1ns/1ps

module mips_load_align import mips_pkg::*; (
    input  logic [1:0]  byte_offset,
    input  mem_size_e   size,
    input  logic        load_unsigned,
    input  logic [31:0] mem_word,
    output logic [31:0] load_value
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // big-endian, offset 0 is the top byte
    always_comb begin
        case (byte_offset)
            2'd0:    sel_byte = mem_word[31:24];
            2'd1:    sel_byte = mem_word[23:16];
            2'd2:    sel_byte = mem_word[15:8];
            default: sel_byte = mem_word[7:0];
        endcase
    end

    assign sel_half = byte_offset[1] ? mem_word[15:0] : mem_word[31:16];

    always_comb begin
        case (size)
            size_byte: begin
                if (load_unsigned) begin
                    load_value = {24'd0, sel_byte};
                end else begin
                    load_value = {{24{sel_byte[7]}}, sel_byte};
                end
            end
            size_half: begin
                if (load_unsigned) begin
                    load_value = {16'd0, sel_half};
                end else begin
                    load_value = {{16{sel_half[15]}}, sel_half};
                end
            end
            default: load_value = mem_word;
        endcase
    end

endmodule

// File: design/mips_pkg.sv
package mips_pkg;

    // primary opcodes in use
    typedef enum logic [5:0] {
        op_special = 6'd0,
        op_regimm  = 6'd1,
        op_j       = 6'd2,
        op_jal     = 6'd3,
        op_beq     = 6'd4,
        op_bne     = 6'd5,
        op_blez    = 6'd6,
        op_bgtz    = 6'd7,
        op_addi    = 6'd8,
        op_addiu   = 6'd9,
        op_slti    = 6'd10,
        op_sltiu   = 6'd11,
        op_andi    = 6'd12,
        op_ori     = 6'd13,
        op_xori    = 6'd14,
        op_lui     = 6'd15,
        op_lb      = 6'd32,
        op_lh      = 6'd33,
        op_lw      = 6'd35,
        op_lbu     = 6'd36,
        op_lhu     = 6'd37,
        op_sb      = 6'd40,
        op_sh      = 6'd41,
        op_sw      = 6'd43
    } opcode_e;

    // r-type function field
    typedef enum logic [5:0] {
        fn_sll   = 6'd0,
        fn_srl   = 6'd2,
        fn_sra   = 6'd3,
        fn_sllv  = 6'd4,
        fn_srlv  = 6'd6,
        fn_srav  = 6'd7,
        fn_jr    = 6'd8,
        fn_jalr  = 6'd9,
        fn_mfhi  = 6'd16,
        fn_mflo  = 6'd18,
        fn_mult  = 6'd24,
        fn_multu = 6'd25,
        fn_div   = 6'd26,
        fn_divu  = 6'd27,
        fn_add   = 6'd32,
        fn_addu  = 6'd33,
        fn_sub   = 6'd34,
        fn_subu  = 6'd35,
        fn_and   = 6'd36,
        fn_or    = 6'd37,
        fn_xor   = 6'd38,
        fn_nor   = 6'd39,
        fn_slt   = 6'd42,
        fn_sltu  = 6'd43
    } funct_e;

    typedef enum logic [4:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt, alu_sltu,
        alu_sll, alu_srl, alu_sra, alu_lui, alu_mult, alu_multu, alu_div, alu_divu,
        alu_pass
    } alu_op_e;

    typedef enum logic {
        st_fetch   = 1'b0,
        st_execute = 1'b1
    } cpu_state_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        logic      imm_zero_ext;
        logic      shift_by_reg;
        logic      reg_write;
        logic      reg_dst_rd;
        logic      link_ra;
        logic      link;
        logic      mem_read;
        logic      mem_write;
        mem_size_e mem_size;
        logic      load_unsigned;
        logic      muldiv;
        logic      from_hi;
        logic      from_lo;
        logic      branch;
        logic      jump_imm;
        logic      jump_reg;
    } ctrl_t;

    localparam logic [31:0] reset_pc = 32'hBFC0_0000;
    localparam logic [4:0] link_reg_index = 5'd31;

endpackage

// File: design/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    input  logic [4:0]  read_index_a,
    input  logic [4:0]  read_index_b,
    input  logic        write_enable,
    input  logic [4:0]  write_index,
    input  logic [31:0] write_data,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b,
    output logic [31:0] register_v0
);

    logic [31:0] regs [1:31];

    // register 0 is hardwired
    assign read_data_a = (read_index_a == 5'd0) ? 32'd0 : regs[read_index_a];
    assign read_data_b = (read_index_b == 5'd0) ? 32'd0 : regs[read_index_b];
    assign register_v0 = regs[2];

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            if (reset) begin
                for (int i = 1; i < 32; i++) begin
                    regs[i] <= '0;
                end
            end else if (write_enable && write_index != 5'd0) begin
                regs[write_index] <= write_data;
            end
        end
    end

endmodule

// File: design/mips_store_merge.sv
`timescale 1ns/1ps

module mips_store_merge import mips_pkg::*; (
    input  logic [1:0]  byte_offset,
    input  mem_size_e   size,
    input  logic [31:0] reg_value,
    input  logic [31:0] old_word,
    output logic [31:0] store_word
);

    always_comb begin
        store_word = old_word;
        case (size)
            size_byte: begin
                case (byte_offset)
                    2'd0:    store_word[31:24] = reg_value[7:0];
                    2'd1:    store_word[23:16] = reg_value[7:0];
                    2'd2:    store_word[15:8] = reg_value[7:0];
                    default: store_word[7:0] = reg_value[7:0];
                endcase
            end
            size_half: begin
                // halfword lane by offset bit 1
                if (byte_offset[1]) begin
                    store_word[15:0] = reg_value[15:0];
                end else begin
                    store_word[31:16] = reg_value[15:0];
                end
            end
            default: store_word = reg_value;
        endcase
    end

endmodule

// File: test/mips_tb.sv
`timescale 1ns/1ps

module mips_tb import mips_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        clk_enable;
    logic        active;
    logic        data_write;
    logic        data_read;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    logic [31:0] prog [128];
    logic [31:0] exp_v0 [128];
    logic [31:0] store_addr [128];
    logic [31:0] store_data [128];
    bit          has_v0 [128];
    bit          has_store [128];
    bit          skipped [128];
    logic [31:0] ram_model [64];
    int          prog_len;
    int          errors;
    int          exec_count;
    int          exec_expected;
    int          cycles;
    int          cycle_limit;
    int          stall_slot;
    integer      seed;
    bit          in_execute;
    bit          timed_out;

    mips_cpu_harvard DUT (
        .clk(clk),
        .reset(reset),
        .active(active),
        .register_v0(register_v0),
        .clk_enable(clk_enable),
        .instr_address(instr_address),
        .instr_readdata(instr_readdata),
        .data_address(data_address),
        .data_write(data_write),
        .data_read(data_read),
        .data_writedata(data_writedata),
        .data_readdata(data_readdata)
    );

    mips_tb_mem mem (
        .clk(clk),
        .clk_enable(clk_enable),
        .instr_address(instr_address),
        .instr_readdata(instr_readdata),
        .data_address(data_address),
        .data_write(data_write),
        .data_writedata(data_writedata),
        .data_readdata(data_readdata)
    );

    // every address bit changes the pattern
    function automatic logic [31:0] fill_word(input int idx);
        return 32'h9A3C_F015 ^ (idx * 32'h0107_0B0D) ^ {idx[7:0], 24'd0};
    endfunction

    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input funct_e fn);
        return {6'd0, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input opcode_e op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] addr_of(input int idx);
        return reset_pc + 32'(4 * idx);
    endfunction

    // loads read during execute and sb/sh read the old word during fetch
    function automatic bit data_read_expected(input logic [31:0] word, input bit execute);
        opcode_e op;
        op = opcode_e'(word[31:26]);
        if (execute) begin
            return op == op_lb || op == op_lbu || op == op_lh || op == op_lhu || op == op_lw;
        end
        return op == op_sb || op == op_sh;
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic expect_v0(input logic [31:0] word, input logic [31:0] value);
        has_v0[prog_len] = 1'b1;
        exp_v0[prog_len] = value;
        emit(word);
    endtask

    task automatic unreachable(input logic [31:0] word);
        skipped[prog_len] = 1'b1;
        emit(word);
    endtask

    task automatic expect_store(input logic [31:0] word, input logic [31:0] addr,
                                input logic [31:0] data);
        has_store[prog_len] = 1'b1;
        store_addr[prog_len] = addr;
        store_data[prog_len] = data;
        ram_model[addr[7:2]] = data;
        emit(word);
    endtask

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic build_program();
        logic [31:0] v;
        logic [31:0] w;
        logic [63:0] p;
        longint      sa;
        longint      sb;
        int          qa;
        int          qb;
        int          b;
        prog_len = 0;
        for (b = 0; b < 64; b++) begin
            ram_model[b] = fill_word(b);
        end
        // alu chain
        v = 32'h0000_1234;
        expect_v0(enc_i(op_addiu, 0, 2, 16'h1234), v);
        emit(enc_i(op_ori, 0, 8, 16'h8000));
        emit(enc_i(op_lui, 0, 9, 16'hF00D));
        v = v + 32'hF00D_0000;
        expect_v0(enc_r(2, 9, 2, 0, fn_addu), v);
        v = v - 32'h0000_8000;
        expect_v0(enc_r(2, 8, 2, 0, fn_subu), v);
        v = v << 4;
        expect_v0(enc_r(0, 2, 2, 4, fn_sll), v);
        v = $signed(32'hF00D_0000) >>> 8;
        expect_v0(enc_r(0, 9, 2, 8, fn_sra), v);
        expect_v0(enc_r(9, 8, 2, 0, fn_slt), 32'd1);
        expect_v0(enc_r(9, 8, 2, 0, fn_sltu), 32'd0);
        expect_v0(enc_r(9, 8, 2, 0, fn_nor), ~(32'hF00D_0000 | 32'h0000_8000));
        // hi and lo with -7 and 3
        emit(enc_i(op_addiu, 0, 10, 16'hFFF9));
        emit(enc_i(op_addiu, 0, 11, 16'h0003));
        sa = -7;
        sb = 3;
        p = sa * sb;
        emit(enc_r(10, 11, 0, 0, fn_mult));
        expect_v0(enc_r(0, 0, 2, 0, fn_mfhi), p[63:32]);
        expect_v0(enc_r(0, 0, 2, 0, fn_mflo), p[31:0]);
        p = 64'h0000_0000_FFFF_FFF9 * 64'd3;
        emit(enc_r(10, 11, 0, 0, fn_multu));
        expect_v0(enc_r(0, 0, 2, 0, fn_mfhi), p[63:32]);
        expect_v0(enc_r(0, 0, 2, 0, fn_mflo), p[31:0]);
        qa = -7;
        qb = 3;
        emit(enc_r(10, 11, 0, 0, fn_div));
        expect_v0(enc_r(0, 0, 2, 0, fn_mflo), 32'(qa / qb));
        expect_v0(enc_r(0, 0, 2, 0, fn_mfhi), 32'(qa % qb));
        emit(enc_r(10, 11, 0, 0, fn_divu));
        expect_v0(enc_r(0, 0, 2, 0, fn_mflo), 32'hFFFF_FFF9 / 32'd3);
        expect_v0(enc_r(0, 0, 2, 0, fn_mfhi), 32'hFFFF_FFF9 % 32'd3);
        // big-endian loads from every lane of word 4
        w = ram_model[4];
        for (b = 0; b < 4; b++) begin
            expect_v0(enc_i(op_lb, 0, 2, 16'(16 + b)), {{24{w[31 - 8 * b]}}, w[31 - 8 * b -: 8]});
            expect_v0(enc_i(op_lbu, 0, 2, 16'(16 + b)), {24'd0, w[31 - 8 * b -: 8]});
        end
        for (b = 0; b < 4; b += 2) begin
            expect_v0(enc_i(op_lh, 0, 2, 16'(16 + b)), {{16{w[31 - 8 * b]}}, w[31 - 8 * b -: 16]});
            expect_v0(enc_i(op_lhu, 0, 2, 16'(16 + b)), {16'd0, w[31 - 8 * b -: 16]});
        end
        expect_v0(enc_i(op_lw, 0, 2, 16'h0010), w);
        // stores into words 6 and 7
        emit(enc_i(op_lui, 0, 12, 16'h1357));
        emit(enc_i(op_ori, 12, 12, 16'h9BDF));
        w = ram_model[6];
        w[23:16] = 8'hDF;
        expect_store(enc_i(op_sb, 0, 12, 16'h0019), 32'h18, w);
        expect_v0(enc_i(op_lw, 0, 2, 16'h0018), w);
        w[15:0] = 16'h9BDF;
        expect_store(enc_i(op_sh, 0, 12, 16'h001A), 32'h18, w);
        expect_v0(enc_i(op_lw, 0, 2, 16'h0018), w);
        w[31:24] = 8'hDF;
        expect_store(enc_i(op_sb, 0, 12, 16'h0018), 32'h18, w);
        expect_store(enc_i(op_sw, 0, 12, 16'h001C), 32'h1C, 32'h1357_9BDF);
        expect_v0(enc_i(op_lw, 0, 2, 16'h001C), 32'h1357_9BDF);
        expect_v0(enc_i(op_lw, 0, 2, 16'h0018), w);
        // branches and jumps where every delay slot adds one
        expect_v0(enc_i(op_addiu, 0, 2, 16'd1), 32'd1);
        emit(enc_i(op_beq, 0, 0, 16'd2));
        expect_v0(enc_i(op_addiu, 2, 2, 16'd1), 32'd2);
        unreachable(enc_i(op_addiu, 2, 2, 16'h0100));
        emit(enc_i(op_bne, 0, 0, 16'd2));
        expect_v0(enc_i(op_addiu, 2, 2, 16'd1), 32'd3);
        expect_v0(enc_i(op_addiu, 2, 2, 16'd1), 32'd4);
        emit(enc_i(op_regimm, 10, 5'b00000, 16'd2));
        expect_v0(enc_i(op_addiu, 2, 2, 16'd1), 32'd5);
        unreachable(enc_i(op_addiu, 2, 2, 16'h0100));
        emit(enc_i(op_blez, 11, 0, 16'd2));
        expect_v0(enc_i(op_addiu, 2, 2, 16'd1), 32'd6);
        expect_v0(enc_i(op_addiu, 2, 2, 16'd1), 32'd7);
        emit(enc_i(op_bgtz, 11, 0, 16'd2));
        expect_v0(enc_i(op_addiu, 2, 2, 16'd1), 32'd8);
        unreachable(enc_i(op_addiu, 2, 2, 16'h0100));
        emit(enc_j(op_j, addr_of(prog_len + 3)));
        expect_v0(enc_i(op_addiu, 2, 2, 16'd1), 32'd9);
        unreachable(enc_i(op_addiu, 2, 2, 16'h0100));
        b = prog_len;
        emit(enc_j(op_jal, addr_of(b + 4)));
        expect_v0(enc_i(op_addiu, 2, 2, 16'd1), 32'd10);
        unreachable(enc_i(op_addiu, 2, 2, 16'h0100));
        unreachable(enc_i(op_addiu, 2, 2, 16'h0100));
        expect_v0(enc_r(31, 0, 2, 0, fn_addu), addr_of(b + 2));
        v = addr_of(b + 2) + 32'd1;
        b = prog_len;
        emit(enc_i(op_regimm, 11, 5'b10001, 16'd2));
        expect_v0(enc_i(op_addiu, 2, 2, 16'd1), v);
        unreachable(enc_i(op_addiu, 2, 2, 16'h0100));
        expect_v0(enc_r(31, 0, 2, 0, fn_addu), addr_of(b + 2));
        // jump to address 0 ends the run
        emit(enc_r(0, 0, 0, 0, fn_jr));
        unreachable(32'd0);
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // one cycle in seven runs with the clock disabled
    initial begin
        seed = 32'h3477ed3c;
        stall_slot = $unsigned($random(seed)) % 7;
        clk_enable = 1'b1;
        cycles = 0;
        forever begin
            @(posedge clk);
            #1;
            cycles++;
            clk_enable = (cycles % 7) != stall_slot;
        end
    end

    always @(posedge clk) begin : monitor
        logic [31:0] addr_before;
        logic [31:0] v0_before;
        int          idx;
        addr_before = instr_address;
        v0_before = register_v0;
        idx = int'((instr_address - reset_pc) >> 2);
        if (active === 1'b0) begin
            assert (data_write !== 1'b1) else begin
                $display("data_write rose at %0t after the CPU halted", $time);
                errors++;
            end
        end
        if (clk_enable && reset) begin
            in_execute = 1'b0;
        end else if (clk_enable && active === 1'b1) begin
            compare_word("data_read", {31'd0, data_read},
                         {31'd0, data_read_expected(prog[idx], in_execute)});
            if (!in_execute && data_read_expected(prog[idx], 1'b0)) begin
                compare_word("data_address of the old word", data_address, store_addr[idx]);
            end
            if (data_write) begin
                assert (has_store[idx]) else begin
                    $display("unexpected memory write from instruction at %h", instr_address);
                    errors++;
                end
                if (has_store[idx]) begin
                    compare_word("data_address", data_address, store_addr[idx]);
                    compare_word("data_writedata", data_writedata, store_data[idx]);
                end
            end
            if (in_execute) begin
                exec_count++;
                assert (!skipped[idx]) else begin
                    $display("instruction at %h ran on a path that should skip it",
                             instr_address);
                    errors++;
                end
            end
            #0.5;
            if (in_execute && has_v0[idx]) begin
                compare_word("register_v0", register_v0, exp_v0[idx]);
            end
            in_execute = !in_execute;
        end else if (!clk_enable && active === 1'b1) begin
            #0.5;
            compare_word("instr_address during stall", instr_address, addr_before);
            compare_word("register_v0 during stall", register_v0, v0_before);
        end
    end

    initial begin
        errors = 0;
        exec_count = 0;
        in_execute = 1'b0;
        timed_out = 1'b0;
        reset = 1'b1;
        build_program();
        exec_expected = 0;
        for (int i = 0; i < 128; i++) begin
            mem.rom[i] = (i < prog_len) ? prog[i] : 32'd0;
            if (i < prog_len && !skipped[i]) begin
                exec_expected++;
            end
        end
        for (int i = 0; i < 64; i++) begin
            mem.ram[i] = fill_word(i);
        end
        // four times the enabled cycles of the program plus stalls and reset
        cycle_limit = (4 * 2 * prog_len) * 8 / 7 + 10;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        while (active !== 1'b0 && !timed_out) begin
            @(posedge clk);
            timed_out = cycles >= cycle_limit;
        end
        if (timed_out) begin
            $display("the CPU never halted within %0d cycles", cycle_limit);
            errors++;
        end else begin
            repeat (20) @(posedge clk);
            assert (exec_count == exec_expected) else begin
                $display("%0d instructions executed, expected %0d", exec_count, exec_expected);
                errors++;
            end
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: test/mips_tb_mem.sv
`timescale 1ns/1ps

module mips_tb_mem import mips_pkg::*; (
    input  logic        clk,
    input  logic        clk_enable,
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata,
    input  logic [31:0] data_address,
    input  logic        data_write,
    input  logic [31:0] data_writedata,
    output logic [31:0] data_readdata
);

    // 128-word program rom, 64-word data ram
    logic [31:0] rom [128];
    logic [31:0] ram [64];
    logic [31:0] rom_offset;

    assign rom_offset = instr_address - reset_pc;

    // anything outside the rom reads as a nop
    assign instr_readdata = (rom_offset < 32'd512) ? rom[rom_offset[8:2]] : 32'd0;

    // ram repeats every 256 bytes
    assign data_readdata = ram[data_address[7:2]];

    always @(posedge clk) begin
        if (clk_enable && data_write) begin
            ram[data_address[7:2]] <= data_writedata;
        end
    end

endmodule

// File: vlog.f
design/mips_pkg.sv
design/mips_control.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_load_align.sv
design/mips_store_merge.sv
design/mips_cpu_harvard.sv
test/mips_tb_mem.sv
test/mips_tb.sv
